//--- common/nes_pkg.sv
`default_nettype none

package nes_pkg;

    typedef logic [7:0]  buttons_t;   // {A, B, SEL, START, UP, DN, L, R}
    typedef logic [3:0]  player_t;    // Low nibble of the frame's first byte
    typedef logic [15:0] cycles_t;    // Clock cycle counts
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Write request into the button store
    typedef struct packed {
        logic     valid;
        player_t  player;
        buttons_t buttons;
    } btn_wr_t;

    typedef struct packed {
        cycles_t debounce_cycles;
        cycles_t hold_cycles;
    } timing_cfg_t;

    // Register map
    localparam apb_addr_t ADDR_CTRL         = 8'h00;  // Bit 0 enables the stream
    localparam apb_addr_t ADDR_DEBOUNCE     = 8'h04;
    localparam apb_addr_t ADDR_HOLD         = 8'h08;
    localparam apb_addr_t ADDR_BUTTONS_BASE = 8'h10;  // Player p at base + 4p

    localparam cycles_t DEBOUNCE_RESET = 16'd4;
    localparam cycles_t HOLD_RESET     = 16'd8;
    localparam logic    CTRL_RESET     = 1'b1;

    localparam logic [3:0] FRAME_SYNC = 4'hA;  // Upper nibble of first byte

endpackage : nes_pkg

`default_nettype wire

//--- logic/line_conditioner.sv
`default_nettype none

module line_conditioner (
    input  logic             clk,
    input  logic             rst,
    input  logic             latch_raw,
    input  logic             pulse_raw,
    input  nes_pkg::cycles_t debounce_cycles,
    output logic             latch_c,
    output logic             pulse_c
);
    import nes_pkg::*;

    // Index 0 is latch and index 1 is pulse
    logic [1:0] sync_q1;
    logic [1:0] sync_q2;
    logic [1:0] level_q;
    cycles_t    stable_cnt [2];

    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1 <= 2'b00;
            sync_q2 <= 2'b00;
        end else begin
            sync_q1 <= {pulse_raw, latch_raw};
            sync_q2 <= sync_q1;
        end
    end

    // Commit a new level once it has held for debounce_cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            level_q       <= 2'b00;
            stable_cnt[0] <= '0;
            stable_cnt[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (sync_q2[i] != level_q[i]) begin
                    if (stable_cnt[i] + cycles_t'(1) >= debounce_cycles) begin
                        level_q[i]    <= sync_q2[i];
                        stable_cnt[i] <= '0;
                    end else begin
                        stable_cnt[i] <= stable_cnt[i] + cycles_t'(1);
                    end
                end else begin
                    stable_cnt[i] <= '0;  // Glitch ended early
                end
            end
        end
    end

    assign latch_c = level_q[0];
    assign pulse_c = level_q[1];

endmodule : line_conditioner

`default_nettype wire

//--- nes_port/nes_port_shifter.sv
`default_nettype none

module nes_port_shifter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 latch_c,
    input  logic                 pulse_c,
    input  nes_pkg::buttons_t    buttons,
    input  nes_pkg::timing_cfg_t timing,
    output logic                 data
);
    import nes_pkg::*;

    typedef enum logic [2:0] {
        idle,
        latched,
        shift_high,
        hold,
        shift_low
    } state_t;

    state_t     state;
    buttons_t   snapshot;
    logic [2:0] bit_idx;   // Bits already presented, minus one
    cycles_t    hold_cnt;

    always_ff @(posedge clk) begin
        if (latch_c && state == idle) begin
            snapshot <= buttons;  // Frozen for the whole read
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            data     <= 1'b1;
            bit_idx  <= '0;
            hold_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    data <= 1'b1;
                    if (latch_c) begin
                        state <= latched;
                    end
                end
                latched: begin
                    if (!latch_c) begin
                        data    <= ~snapshot[7];  // A goes out first
                        bit_idx <= '0;
                        state   <= shift_low;
                    end
                end
                shift_low: begin
                    if (pulse_c) begin
                        state <= shift_high;
                    end
                end
                shift_high: begin
                    if (!pulse_c) begin
                        hold_cnt <= '0;
                        state    <= hold;
                    end
                end
                hold: begin
                    if (hold_cnt >= timing.hold_cycles) begin
                        if (bit_idx == 3'd7) begin
                            data  <= 1'b1;  // Eighth pulse done
                            state <= idle;
                        end else begin
                            data    <= ~snapshot[3'd6 - bit_idx];
                            bit_idx <= bit_idx + 3'd1;
                            state   <= shift_low;
                        end
                    end else begin
                        hold_cnt <= hold_cnt + cycles_t'(1);
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    a_idle_data_high: assert property (@(posedge clk) disable iff (rst)
        state == idle |-> data)
        else $error("nes_port_shifter data low in idle");

endmodule : nes_port_shifter

`default_nettype wire

//--- logic/frame_decoder.sv
`default_nettype none

module frame_decoder #(
    parameter int NUM_PORTS = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              stream_valid,
    input  nes_pkg::buttons_t stream_byte,
    input  logic              stream_enable,
    input  logic              dec_grant,
    output nes_pkg::btn_wr_t  dec_wr
);
    import nes_pkg::*;

    typedef enum logic {
        wait_sync,
        wait_data
    } state_t;

    state_t   state;
    player_t  frame_player;
    logic     wr_valid;
    player_t  wr_player;
    buttons_t wr_buttons;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= wait_sync;
            wr_valid <= 1'b0;
        end else if (wr_valid) begin
            if (dec_grant) begin
                wr_valid <= 1'b0;
            end
        end else if (stream_valid) begin  // Bytes during a pending request are lost
            case (state)
                wait_sync: begin
                    if (stream_byte[7:4] == FRAME_SYNC) begin
                        state <= wait_data;
                    end
                end
                default: begin
                    state <= wait_sync;
                    if (stream_enable && frame_player < player_t'(NUM_PORTS)) begin
                        wr_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!wr_valid && stream_valid) begin
            if (state == wait_sync) begin
                frame_player <= stream_byte[3:0];
            end else begin
                wr_player  <= frame_player;
                wr_buttons <= stream_byte;
            end
        end
    end

    assign dec_wr = '{valid: wr_valid, player: wr_player, buttons: wr_buttons};

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        dec_wr.valid && !dec_grant |=> $stable(dec_wr))
        else $error("frame_decoder dec_wr changed before grant");

endmodule : frame_decoder

`default_nettype wire

//--- logic/apb_regs.sv
`default_nettype none

module apb_regs #(
    parameter int NUM_PORTS = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  nes_pkg::apb_addr_t   paddr,
    input  nes_pkg::apb_data_t   pwdata,
    input  logic                 apb_grant,
    input  nes_pkg::buttons_t    rd_buttons,
    output nes_pkg::apb_data_t   prdata,
    output logic                 pready,
    output logic                 pslverr,
    output nes_pkg::btn_wr_t     apb_wr,
    output nes_pkg::player_t     rd_player,
    output logic                 stream_enable,
    output nes_pkg::timing_cfg_t timing
);
    import nes_pkg::*;

    logic      setup_phase;
    logic      access_phase;
    apb_addr_t btn_offset;
    logic      btn_hit;
    logic      cfg_hit;
    logic      ctrl_en;
    cycles_t   debounce_q;
    cycles_t   hold_q;
    logic      wr_valid;
    player_t   wr_player;
    buttons_t  wr_buttons;

    assign setup_phase  = psel && !penable;
    assign access_phase = psel && penable;

    assign btn_offset = paddr - ADDR_BUTTONS_BASE;
    assign rd_player  = {2'b00, btn_offset[3:2]};
    assign btn_hit    = btn_offset[7:4] == 4'h0 && btn_offset[1:0] == 2'b00 &&
                        rd_player < player_t'(NUM_PORTS);
    assign cfg_hit    = paddr == ADDR_CTRL || paddr == ADDR_DEBOUNCE || paddr == ADDR_HOLD;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_en    <= CTRL_RESET;
            debounce_q <= DEBOUNCE_RESET;
            hold_q     <= HOLD_RESET;
        end else if (access_phase && pwrite) begin
            case (paddr)
                ADDR_CTRL:     ctrl_en    <= pwdata[0];
                ADDR_DEBOUNCE: debounce_q <= pwdata[15:0];
                ADDR_HOLD:     hold_q     <= pwdata[15:0];
                default:       ;
            endcase
        end
    end

    // Button write request raised during setup so the grant can land in access
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid <= 1'b0;
        end else if (wr_valid && apb_grant) begin
            wr_valid <= 1'b0;
        end else if (setup_phase && pwrite && btn_hit) begin
            wr_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (setup_phase && pwrite && btn_hit) begin
            wr_player  <= rd_player;
            wr_buttons <= pwdata[7:0];
        end
    end

    assign apb_wr = '{valid: wr_valid, player: wr_player, buttons: wr_buttons};

    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        if (access_phase) begin
            pready  = (btn_hit && pwrite) ? apb_grant : 1'b1;  // Stall until store grants
            pslverr = !(btn_hit || cfg_hit);
        end
    end

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                ADDR_CTRL:     prdata = {31'h0, ctrl_en};
                ADDR_DEBOUNCE: prdata = {16'h0, debounce_q};
                ADDR_HOLD:     prdata = {16'h0, hold_q};
                default:       prdata = btn_hit ? {24'h0, rd_buttons} : '0;
            endcase
        end
    end

    assign stream_enable = ctrl_en;
    assign timing        = '{debounce_cycles: debounce_q, hold_cycles: hold_q};

    a_pready_in_access: assert property (@(posedge clk) disable iff (rst)
        pready |-> psel && penable)
        else $error("apb_regs pready outside access phase");

endmodule : apb_regs

`default_nettype wire

//--- logic/button_store.sv
`default_nettype none

module button_store #(
    parameter int NUM_PORTS = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  nes_pkg::btn_wr_t  apb_wr,
    input  nes_pkg::btn_wr_t  dec_wr,
    input  nes_pkg::player_t  rd_player,
    output logic              apb_grant,
    output logic              dec_grant,
    output nes_pkg::buttons_t rd_buttons,
    output nes_pkg::buttons_t port_buttons [NUM_PORTS]
);
    import nes_pkg::*;

    buttons_t btn_q [NUM_PORTS];
    btn_wr_t  wr_sel;

    // Fixed priority with APB ahead of the decoder
    assign apb_grant = apb_wr.valid;
    assign dec_grant = dec_wr.valid && !apb_wr.valid;
    assign wr_sel    = apb_grant ? apb_wr : dec_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                btn_q[p] <= '0;
            end
        end else if (wr_sel.valid) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (wr_sel.player == player_t'(p)) begin
                    btn_q[p] <= wr_sel.buttons;
                end
            end
        end
    end

    always_comb begin
        rd_buttons = '0;  // Out of range reads return zero
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rd_player == player_t'(p)) begin
                rd_buttons = btn_q[p];
            end
        end
    end

    assign port_buttons = btn_q;

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(apb_grant && dec_grant))
        else $error("button_store both grants asserted");

endmodule : button_store

`default_nettype wire

//--- logic/nes_bridge_top.sv
`default_nettype none

module nes_bridge_top #(
    parameter int NUM_PORTS = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               stream_valid,
    input  nes_pkg::buttons_t  stream_byte,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  nes_pkg::apb_addr_t paddr,
    input  nes_pkg::apb_data_t pwdata,
    input  logic               latch [NUM_PORTS],
    input  logic               pulse [NUM_PORTS],
    output nes_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               data [NUM_PORTS]
);
    import nes_pkg::*;

    btn_wr_t     apb_wr;
    btn_wr_t     dec_wr;
    logic        apb_grant;
    logic        dec_grant;
    player_t     rd_player;
    buttons_t    rd_buttons;
    buttons_t    port_buttons [NUM_PORTS];
    logic        stream_enable;
    timing_cfg_t timing;

    frame_decoder #(.NUM_PORTS(NUM_PORTS)) frame_decoder_inst (
        .clk, .rst, .stream_valid, .stream_byte, .stream_enable, .dec_grant, .dec_wr
    );

    apb_regs #(.NUM_PORTS(NUM_PORTS)) apb_regs_inst (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .apb_grant, .rd_buttons,
        .prdata, .pready, .pslverr, .apb_wr, .rd_player, .stream_enable, .timing
    );

    button_store #(.NUM_PORTS(NUM_PORTS)) button_store_inst (
        .clk, .rst, .apb_wr, .dec_wr, .rd_player,
        .apb_grant, .dec_grant, .rd_buttons, .port_buttons
    );

    // One console port per player
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        logic latch_c;
        logic pulse_c;

        line_conditioner line_conditioner_inst (
            .clk,
            .rst,
            .latch_raw       (latch[g]),
            .pulse_raw       (pulse[g]),
            .debounce_cycles (timing.debounce_cycles),
            .latch_c         (latch_c),
            .pulse_c         (pulse_c)
        );

        nes_port_shifter nes_port_shifter_inst (
            .clk,
            .rst,
            .latch_c (latch_c),
            .pulse_c (pulse_c),
            .buttons (port_buttons[g]),
            .timing  (timing),
            .data    (data[g])
        );
    end

endmodule : nes_bridge_top

`default_nettype wire

//--- verif/tb_nes_bridge.sv
`default_nettype none

module tb_nes_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    import nes_pkg::*;

    localparam int NUM_PORTS    = 2;
    localparam int APB_TIMEOUT  = 20;   // Cycles allowed for pready
    localparam int GLITCH_CYCLES = 2;   // Kept below the debounce count

    logic      clk;
    logic      rst;
    logic      stream_valid;
    buttons_t  stream_byte;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    logic      latch [NUM_PORTS];
    logic      pulse [NUM_PORTS];
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      data [NUM_PORTS];

    integer    seed;
    integer    rnd;
    int        cur_debounce;
    int        cur_hold;
    buttons_t  exp_btn [NUM_PORTS];   // Reference copy of the button store
    buttons_t  apb_val;
    buttons_t  dec_val;
    apb_data_t rdata;
    logic      err;

    nes_bridge_top #(.NUM_PORTS(NUM_PORTS)) nes_bridge_top_inst (
        .clk, .rst, .stream_valid, .stream_byte, .psel, .penable, .pwrite, .paddr, .pwdata,
        .latch, .pulse, .prdata, .pready, .pslverr, .data
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic apb_addr_t btn_addr(input int p);
        return ADDR_BUTTONS_BASE + apb_addr_t'(4 * p);
    endfunction

    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rd, output logic slverr);
        int waited;
        @(negedge clk);
        psel    = 1'b1;   // Setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waited  = 0;
        @(posedge clk);
        while (pready !== 1'b1) begin
            if (waited >= APB_TIMEOUT) begin
                $display("Timeout waiting for pready at address 0x%0h", addr);
                report_failure();
            end
            waited++;
            @(posedge clk);
        end
        rd     = prdata;
        slverr = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
        apb_data_t rd;
        logic      slverr;
        apb_access(1'b1, addr, wdata, rd, slverr);
        check_value($sformatf("pslverr on write 0x%0h", addr), slverr, 0);
    endtask

    task automatic apb_read_check(input apb_addr_t addr, input apb_data_t exp);
        apb_data_t rd;
        logic      slverr;
        apb_access(1'b0, addr, '0, rd, slverr);
        check_value($sformatf("pslverr on read 0x%0h", addr), slverr, 0);
        check_value($sformatf("prdata at 0x%0h", addr), rd, exp);
    endtask

    task automatic send_frame(input buttons_t first, input buttons_t second);
        @(negedge clk);
        stream_valid = 1'b1;
        stream_byte  = first;
        @(negedge clk);
        stream_byte  = second;
        @(negedge clk);
        stream_valid = 1'b0;
    endtask

    // Console side of one port, with an optional short glitch before bit glitch_bit
    task automatic nes_read(input int port, input buttons_t exp, input int glitch_bit);
        int low_cycles;
        int high_cycles;
        low_cycles  = cur_debounce + cur_hold + 6;
        high_cycles = cur_debounce + 4;
        @(negedge clk);
        check_value($sformatf("data[%0d] before latch", port), data[port], 1);
        latch[port] = 1'b1;
        wait_cycles(high_cycles);
        latch[port] = 1'b0;
        for (int i = 0; i < 8; i++) begin
            wait_cycles(low_cycles);
            if (i == glitch_bit) begin
                pulse[port] = 1'b1;
                wait_cycles(GLITCH_CYCLES);
                pulse[port] = 1'b0;
                wait_cycles(low_cycles);
            end
            check_value($sformatf("data[%0d] bit %0d", port, i), data[port], !exp[7 - i]);
            pulse[port] = 1'b1;
            wait_cycles(high_cycles);
            pulse[port] = 1'b0;
        end
        wait_cycles(low_cycles);   // Shifter is back in idle by now
        check_value($sformatf("data[%0d] after read", port), data[port], 1);
    endtask

    a_err_completes: assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
        else begin
            $display("Error: pslverr is 0x%0h while pready is 0x%0h", pslverr, pready);
            report_failure();
        end

    a_ready_needs_sel: assert property (@(posedge clk) disable iff (rst) !psel |-> !pready)
        else begin
            $display("Error: pready is 0x%0h while psel is 0x%0h", pready, psel);
            report_failure();
        end

    initial begin
        seed         = 32'h8f1469a5;
        cur_debounce = DEBOUNCE_RESET;
        cur_hold     = HOLD_RESET;
        rst          = 1'b1;
        stream_valid = 1'b0;
        stream_byte  = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            latch[p]   = 1'b0;
            pulse[p]   = 1'b0;
            exp_btn[p] = '0;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Reset values
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("data[%0d] after reset", p), data[p], 1);
        end
        apb_read_check(ADDR_CTRL, 32'(CTRL_RESET));
        apb_read_check(ADDR_DEBOUNCE, 32'(DEBOUNCE_RESET));
        apb_read_check(ADDR_HOLD, 32'(HOLD_RESET));
        for (int p = 0; p < NUM_PORTS; p++) begin
            apb_read_check(btn_addr(p), 0);
        end

        // APB write, readback and console read on port 0
        rnd        = $random(seed);
        exp_btn[0] = rnd[7:0];
        apb_write(btn_addr(0), {24'h0, exp_btn[0]});
        apb_read_check(btn_addr(0), {24'h0, exp_btn[0]});
        nes_read(0, exp_btn[0], -1);

        // Stream frame for player 1, then frames that must be dropped
        rnd        = $random(seed);
        exp_btn[1] = rnd[7:0];
        send_frame({FRAME_SYNC, 4'h1}, exp_btn[1]);
        apb_read_check(btn_addr(1), {24'h0, exp_btn[1]});
        nes_read(1, exp_btn[1], -1);
        rnd = $random(seed);
        send_frame({4'h5, 4'h1}, {4'h3, rnd[3:0]});   // No sync in either byte
        wait_cycles(4);
        apb_read_check(btn_addr(1), {24'h0, exp_btn[1]});
        send_frame({FRAME_SYNC, 4'h5}, rnd[7:0]);
        wait_cycles(4);
        apb_read_check(btn_addr(1), {24'h0, exp_btn[1]});
        apb_write(ADDR_CTRL, 0);
        send_frame({FRAME_SYNC, 4'h1}, ~exp_btn[1]);
        wait_cycles(4);
        apb_read_check(btn_addr(1), {24'h0, exp_btn[1]});
        apb_write(ADDR_CTRL, 1);

        // APB setup phase lines up with the second stream byte
        rnd     = $random(seed);
        apb_val = rnd[7:0];
        dec_val = ~apb_val;
        fork
            send_frame({FRAME_SYNC, 4'h0}, dec_val);
            begin
                @(negedge clk);
                apb_write(btn_addr(0), {24'h0, apb_val});
            end
        join
        exp_btn[0] = dec_val;   // Decoder lands one cycle after APB
        apb_read_check(btn_addr(0), {24'h0, exp_btn[0]});

        // Unmapped address and new timing
        apb_access(1'b0, 8'h40, '0, rdata, err);
        check_value("pslverr at 0x40", err, 1);
        apb_write(ADDR_DEBOUNCE, 6);
        cur_debounce = 6;
        apb_write(ADDR_HOLD, 3);
        cur_hold = 3;
        apb_read_check(ADDR_DEBOUNCE, 6);
        apb_read_check(ADDR_HOLD, 3);
        nes_read(0, exp_btn[0], -1);

        // Short pulse glitch in the middle of a read
        nes_read(1, exp_btn[1], 3);

        $display("Simulation passed");
        $finish;
    end

endmodule : tb_nes_bridge

`default_nettype wire

//--- flist.f
common/nes_pkg.sv
logic/line_conditioner.sv
nes_port/nes_port_shifter.sv
logic/frame_decoder.sv
logic/apb_regs.sv
logic/button_store.sv
logic/nes_bridge_top.sv
verif/tb_nes_bridge.sv

//--- Bender.yml
package:
  name: nes_bridge

sources:
  - files:
      - common/nes_pkg.sv
      - logic/line_conditioner.sv
      - nes_port/nes_port_shifter.sv
      - logic/frame_decoder.sv
      - logic/apb_regs.sv
      - logic/button_store.sv
      - logic/nes_bridge_top.sv
  - target: test
    files:
      - verif/tb_nes_bridge.sv
